//--- list.f
verilog/isolde_pkg.sv
verilog/isolde_instr_buffer.sv
verilog/isolde_decoder.sv
verilog/isolde_cfg_regs.sv
verilog/isolde_frontend_top.sv
tb/isolde_frontend_props.sv
tb/isolde_frontend_checker.sv
tb/isolde_frontend_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the front-end testbench with Verilator, run it, check the log
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert -Wno-fatal --top-module isolde_frontend_tb -f list.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Keep running past assertion errors so the testbench can report them
./obj_dir/Visolde_frontend_tb +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" "$log"; then
  echo "Failures found, see $log"
  exit 1
fi

echo "Simulation clean, see $log"
exit 0

//--- tb/isolde_frontend_checker.sv
// ##########################################################
// Watches the front-end ports on the falling clock edge
// Predictions assume CTRL changes only while the DUT is idle
// ##########################################################

module isolde_frontend_checker import isolde_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           word_valid_i,
  input  logic [WordW-1:0]               word_i,
  input  logic                           full_i,
  input  logic                           reg_we_i,
  input  logic [RegAddrW-1:0]            reg_addr_i,
  input  logic [WordW-1:0]               reg_wdata_i,
  input  logic [WordW-1:0]               reg_rdata_i,
  input  logic [BufDepth-1:0][WordW-1:0] instr_i,
  input  logic [LenW-1:0]                instr_len_i,
  input  logic                           instr_valid_i,
  input  logic                           illegal_i,
  input  logic                           busy_i,
  output int                             pending_o,
  output int                             errors_o,
  output int                             decoded_o,
  output int                             illegal_o
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [WordW-1:0] word_q[$];  // Accepted words not yet consumed
  logic             en_64, en_ge80;
  logic [WordW-1:0] exp_rdata;
  int               exp_decoded, exp_illegal;  // Register model
  int               errors = 0;
  int               decoded_seen = 0;
  int               illegal_seen = 0;
  int               edges;  // Edges since reset release until just past boot
  int               exp_len;

  // Length in words or 0 for illegal
  function automatic int ref_len(input logic [WordW-1:0] w, input logic en64,
                                 input logic enge80);
    if (w[6:0] == 7'b0111111) return en64 ? 2 : 0;
    if (w[6:0] == 7'b1111111 && w[14:12] == 3'd5) return enge80 ? 5 : 0;
    if (w[6:0] == 7'b1111111 && w[14:12] == 3'd1) return enge80 ? 3 : 0;
    return 0;
  endfunction

  task automatic report_mismatch(input string msg);
    errors++;
    $display("Fail at %0d ns: %s", $time, msg);
  endtask

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) edges <= 0;
    else if (edges <= BootCycles) edges <= edges + 1;
  end

  always @(negedge clk_i) begin
    if (!rst_ni) begin
      word_q.delete();
      en_64       = 1'b1;  // Enables come out of reset on
      en_ge80     = 1'b1;
      exp_decoded = 0;
      exp_illegal = 0;
    end else begin
      if (edges <= BootCycles) begin
        if (busy_i !== (edges < BootCycles)) report_mismatch("busy_o wrong during boot");
        if (instr_valid_i || illegal_i) report_mismatch("pulse during boot");
      end
      // Read data reflects state before this cycle's write and pulses
      if (!reg_we_i) begin
        exp_rdata = '0;
        case (reg_addr_i)
          REG_CTRL: begin
            exp_rdata[0] = en_64;
            exp_rdata[1] = en_ge80;
          end
          REG_DECODED: exp_rdata = WordW'(exp_decoded);
          REG_ILLEGAL: exp_rdata = WordW'(exp_illegal);
          default:     exp_rdata = '0;
        endcase
        if (reg_rdata_i !== exp_rdata) begin
          report_mismatch($sformatf("register %0d read %h, expected %h",
                                    reg_addr_i, reg_rdata_i, exp_rdata));
        end
      end
      if (instr_valid_i) begin
        decoded_seen++;
        exp_decoded++;
        exp_len = (word_q.size() > 0) ? ref_len(word_q[0], en_64, en_ge80) : 0;
        if (exp_len == 0) begin
          report_mismatch("instruction released where an illegal word was expected");
        end else if (int'(instr_len_i) != exp_len || word_q.size() < exp_len) begin
          report_mismatch($sformatf("length %0d, expected %0d", instr_len_i, exp_len));
        end else begin
          for (int i = 0; i < exp_len; i++) begin
            if (instr_i[i] !== word_q[i]) begin
              report_mismatch($sformatf("word %0d is %h, expected %h", i, instr_i[i],
                                        word_q[i]));
            end
          end
        end
        if (exp_len == 0) exp_len = int'(instr_len_i);  // Resync on a bad release
        while (exp_len > 0 && word_q.size() > 0) begin
          void'(word_q.pop_front());
          exp_len--;
        end
      end
      if (illegal_i) begin
        illegal_seen++;
        exp_illegal++;
        if (word_q.size() == 0) begin
          report_mismatch("illegal pulse with no word buffered");
        end else begin
          if (ref_len(word_q[0], en_64, en_ge80) != 0) begin
            report_mismatch($sformatf("legal word %h flagged illegal", word_q[0]));
          end
          void'(word_q.pop_front());
        end
      end
      // Words held by the buffer in this cycle
      if (full_i !== (word_q.size() == BufDepth)) begin
        report_mismatch($sformatf("full_o is %b with %0d words buffered", full_i,
                                  word_q.size()));
      end
      if (reg_we_i) begin
        case (reg_addr_i)
          REG_CTRL: begin
            en_64   = reg_wdata_i[0];
            en_ge80 = reg_wdata_i[1];
          end
          REG_DECODED: exp_decoded = 0;
          REG_ILLEGAL: exp_illegal = 0;
          default: ;
        endcase
      end
      if (word_valid_i && !full_i) word_q.push_back(word_i);  // Lands at next edge
    end
    pending_o = word_q.size();
  end

  assign errors_o  = errors;
  assign decoded_o = decoded_seen;
  assign illegal_o = illegal_seen;

endmodule

//--- tb/isolde_frontend_props.sv
// ##########################################################
// Port assertions, bound into the front-end top level
// Pulse and push rules only, data is left to the checker
// ##########################################################

module isolde_frontend_props import isolde_pkg::*; (
  input logic            clk_i,
  input logic            rst_ni,
  input logic            word_valid_i,
  input logic            full_i,
  input logic            instr_valid_i,
  input logic            illegal_i,
  input logic [LenW-1:0] instr_len_i
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0;  // Summed into the final error count
  int          boot_cnt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      boot_cnt <= 0;
    end else if (boot_cnt < BootCycles) begin
      boot_cnt <= boot_cnt + 1;  // Saturates once boot is over
    end
  end

  // One answer per word
  no_double_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(instr_valid_i && illegal_i))
    else begin
      fail_cnt++;
      $error("instr_valid_o and illegal_o high in the same cycle");
    end

  legal_len_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_valid_i |-> (instr_len_i inside {3'd2, 3'd3, 3'd5}))
    else begin
      fail_cnt++;
      $error("instr_len_o is not 2, 3 or 5 on a release");
    end

  quiet_boot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (boot_cnt < BootCycles) |-> !(instr_valid_i || illegal_i))
    else begin
      fail_cnt++;
      $error("decoder pulse inside the boot period");
    end

  // Source side rule
  no_push_full_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    word_valid_i |-> !full_i)
    else begin
      fail_cnt++;
      $error("word_valid_i high while full_o is high");
    end

endmodule

bind isolde_frontend_top isolde_frontend_props isolde_frontend_props_inst (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .word_valid_i (word_valid_i),
  .full_i       (full_o),
  .instr_valid_i(instr_valid_o),
  .illegal_i    (illegal_o),
  .instr_len_i  (instr_len_o)
);

//--- tb/isolde_frontend_tb.sv
// ##########################################################
// Front-end testbench running six tests and a summary line
// Inputs change 1 ns after the rising clock edge
// Data checks live in the checker and the bound props
// ##########################################################

module isolde_frontend_tb import isolde_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NumRounds     = 4;   // 2-, 3- and 5-word groups in test 2
  localparam int NumRandInstr  = 60;  // Instructions in the random stream
  localparam int TotalWords    = NumRounds * 10 + 7 + 22 + 3 + NumRandInstr * BufDepth;
  localparam int TimeoutCycles = 200 + 12 * TotalWords;  // Covers gaps and decode

  logic                           clk_i, rst_ni;
  logic                           word_valid_i, full_o;
  logic [WordW-1:0]               word_i;
  logic                           reg_we_i;
  logic [RegAddrW-1:0]            reg_addr_i;
  logic [WordW-1:0]               reg_wdata_i, reg_rdata_o;
  logic [BufDepth-1:0][WordW-1:0] instr_o;
  logic [LenW-1:0]                instr_len_o;
  logic                           instr_valid_o, illegal_o, busy_o;
  int                             pending, check_errors, decoded_seen, illegal_seen;
  int                             test_num = 0;
  int                             errs_at_start;

  isolde_frontend_top isolde_frontend_top_inst (.*);

  isolde_frontend_checker isolde_frontend_checker_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .word_valid_i (word_valid_i),
    .word_i       (word_i),
    .full_i       (full_o),
    .reg_we_i     (reg_we_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .reg_rdata_i  (reg_rdata_o),
    .instr_i      (instr_o),
    .instr_len_i  (instr_len_o),
    .instr_valid_i(instr_valid_o),
    .illegal_i    (illegal_o),
    .busy_i       (busy_o),
    .pending_o    (pending),
    .errors_o     (check_errors),
    .decoded_o    (decoded_seen),
    .illegal_o    (illegal_seen)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;  // 8 ns period
  end

  // Hard stop if the DUT or a wait loop stalls
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TimeoutCycles) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", TimeoutCycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

  function automatic int total_errors();
    return check_errors + int'(isolde_frontend_top_inst.isolde_frontend_props_inst.fail_cnt);
  endfunction

  task automatic idle_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic push_word(input logic [WordW-1:0] w);
    while (full_o) idle_cycle();  // Source holds on full
    word_valid_i = 1'b1;
    word_i       = w;
    idle_cycle();
    word_valid_i = 1'b0;
  endtask

  // Head word with random upper bits and the encoding for len
  function automatic logic [WordW-1:0] make_head(input int len);
    logic [WordW-1:0] w;
    w = $urandom();
    w[6:0] = (len == 2) ? 7'b0111111 : 7'b1111111;
    if (len == 3) w[14:12] = 3'd1;
    if (len == 5) w[14:12] = 3'd5;
    return w;
  endfunction

  task automatic send_instr(input int len, input bit zero_payload, input bit gaps);
    for (int i = 0; i < len; i++) begin
      if (gaps && $urandom_range(0, 3) == 0) begin
        repeat ($urandom_range(1, 3)) idle_cycle();  // Hole in the stream
      end
      if (i == 0) push_word(make_head(len));
      else if (zero_payload) push_word('0);  // Opcode 0 is illegal as a head
      else push_word($urandom());
    end
  endtask

  task automatic write_reg(input reg_addr_e addr, input logic [WordW-1:0] data);
    reg_we_i    = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    idle_cycle();
    reg_we_i    = 1'b0;
    reg_addr_i  = REG_CTRL;
    reg_wdata_i = '0;
  endtask

  task automatic read_reg(input reg_addr_e addr);
    reg_addr_i = addr;  // Checker compares the read data
    idle_cycle();
    reg_addr_i = REG_CTRL;
  endtask

  task automatic wait_drain();
    while (pending != 0 || busy_o) idle_cycle();
  endtask

  task automatic start_test();
    test_num++;
    errs_at_start = total_errors();
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = total_errors() - errs_at_start;
    if (errs == 0) $display("Test %0d %s: ok", test_num, name);
    else $display("Test %0d %s: %0d errors", test_num, name, errs);
  endtask

  initial begin
    logic [WordW-1:0] w;
    int len;
    void'($urandom(32'h899e));  // Single seed for the run
    rst_ni       = 1'b0;
    word_valid_i = 1'b0;
    word_i       = '0;
    reg_we_i     = 1'b0;
    reg_addr_i   = REG_CTRL;
    reg_wdata_i  = '0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    start_test();
    while (busy_o) idle_cycle();  // Checker watches the boot period
    repeat (4) idle_cycle();
    end_test("boot and quiet outputs");

    start_test();
    repeat (NumRounds) begin
      send_instr(2, 1'b0, 1'b0);
      send_instr(3, 1'b0, 1'b0);
      send_instr(5, 1'b0, 1'b0);
    end
    wait_drain();
    end_test("back-to-back lengths");

    start_test();
    w = $urandom();
    w[6:0] = 7'b0110011;  // Standard OP opcode
    push_word(w);
    w = $urandom();
    w[14:12] = 3'd3;  // Custom opcode without a length for this nnn
    w[6:0]   = 7'b1111111;
    push_word(w);
    send_instr(2, 1'b0, 1'b0);
    send_instr(3, 1'b0, 1'b0);
    wait_drain();
    end_test("illegal words");

    start_test();
    write_reg(REG_CTRL, 32'h2);  // 64-bit encoding off
    send_instr(2, 1'b1, 1'b0);
    send_instr(5, 1'b0, 1'b0);
    wait_drain();
    write_reg(REG_CTRL, 32'h1);  // Long encoding off
    send_instr(5, 1'b1, 1'b0);
    send_instr(2, 1'b0, 1'b0);
    wait_drain();
    write_reg(REG_CTRL, 32'h3);
    send_instr(3, 1'b0, 1'b0);
    send_instr(5, 1'b0, 1'b0);
    wait_drain();
    end_test("encoding enables");

    start_test();
    read_reg(REG_DECODED);
    read_reg(REG_ILLEGAL);
    write_reg(REG_DECODED, '0);
    write_reg(REG_ILLEGAL, '0);
    read_reg(REG_DECODED);
    read_reg(REG_ILLEGAL);
    send_instr(2, 1'b0, 1'b0);
    push_word('0);
    wait_drain();
    read_reg(REG_DECODED);
    read_reg(REG_ILLEGAL);
    end_test("counters");

    start_test();
    repeat (NumRandInstr) begin
      case ($urandom_range(0, 2))
        0:       len = 2;
        1:       len = 3;
        default: len = 5;
      endcase
      send_instr(len, 1'b0, 1'b1);
    end
    wait_drain();
    end_test("random stream");

    $display("Summary: %0d tests, %0d instructions, %0d illegal words, %0d errors",
             test_num, decoded_seen, illegal_seen, total_errors());
    if (total_errors() == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- verilog/isolde_cfg_regs.sv
// ##########################################################
// Control enables plus decoded and illegal counters
// Counters saturate, any write to a counter clears it
// A pulse in the cycle of a clearing write is not counted
// ##########################################################

module isolde_cfg_regs import isolde_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Register port
  input  logic                reg_we_i,
  input  logic [RegAddrW-1:0] reg_addr_i,
  input  logic [WordW-1:0]    reg_wdata_i,
  output logic [WordW-1:0]    reg_rdata_o,
  // Event pulses from decoder
  input  logic                decoded_i,
  input  logic                illegal_i,
  // Enables to decoder
  output logic                en_64_o,
  output logic                en_ge80_o
);

  reg_addr_e addr;

  logic             en_64_q, en_ge80_q;
  logic [WordW-1:0] decoded_cnt_q;
  logic [WordW-1:0] illegal_cnt_q;
  logic             wr_ctrl, wr_decoded, wr_illegal;

  assign addr = reg_addr_e'(reg_addr_i);

  // Write decode
  assign wr_ctrl    = reg_we_i && (addr == REG_CTRL);
  assign wr_decoded = reg_we_i && (addr == REG_DECODED);
  assign wr_illegal = reg_we_i && (addr == REG_ILLEGAL);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      en_64_q   <= 1'b1;  // Both encodings on after reset
      en_ge80_q <= 1'b1;
    end else if (wr_ctrl) begin
      en_64_q   <= reg_wdata_i[CtrlEn64Bit];
      en_ge80_q <= reg_wdata_i[CtrlEnGe80Bit];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      decoded_cnt_q <= '0;
    end else if (wr_decoded) begin
      decoded_cnt_q <= '0;
    end else if (decoded_i && (decoded_cnt_q != '1)) begin
      decoded_cnt_q <= decoded_cnt_q + 1'b1;  // Holds at all ones
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      illegal_cnt_q <= '0;
    end else if (wr_illegal) begin
      illegal_cnt_q <= '0;
    end else if (illegal_i && (illegal_cnt_q != '1)) begin
      illegal_cnt_q <= illegal_cnt_q + 1'b1;
    end
  end

  // Combinational read
  always_comb begin
    reg_rdata_o = '0;
    case (addr)
      REG_CTRL: begin
        reg_rdata_o[CtrlEn64Bit]   = en_64_q;
        reg_rdata_o[CtrlEnGe80Bit] = en_ge80_q;
      end
      REG_DECODED: reg_rdata_o = decoded_cnt_q;
      REG_ILLEGAL: reg_rdata_o = illegal_cnt_q;
      default:     reg_rdata_o = '0;  // Address 3 unmapped
    endcase
  end

  assign en_64_o   = en_64_q;
  assign en_ge80_o = en_ge80_q;

endmodule

//--- verilog/isolde_decoder.sv
// ##########################################################
// Sizes the oldest buffered word and releases whole batches
// Busy for BootCycles after reset, then one instr at a time
// Disabled encodings are rejected like unknown opcodes
// ##########################################################

module isolde_decoder import isolde_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // From buffer
  input  logic [BufDepth-1:0][WordW-1:0] buf_words_i,
  input  logic [LenW-1:0]                buf_count_i,
  // From register block
  input  logic                           en_64_i,
  input  logic                           en_ge80_i,
  // To buffer
  output logic [LenW-1:0]                pop_len_o,
  // Released instruction
  output logic [BufDepth-1:0][WordW-1:0] instr_o,
  output logic [LenW-1:0]                instr_len_o,
  output logic                           instr_valid_o,
  output logic                           illegal_o,
  output logic                           busy_o
);

  dec_state_e state_q, state_d;

  logic [BootCntW-1:0] boot_cnt_q;
  logic [LenW-1:0]     len_q;       // Length latched in COMPUTE
  logic [LenW-1:0]     len_calc;
  logic                legal_calc;
  logic                release_now;  // All words of the instr present
  logic [OpcodeW-1:0]  opcode;
  logic [NnnW-1:0]     nnn;

  logic [BufDepth-1:0][WordW-1:0] instr_q;
  logic [LenW-1:0]                instr_len_q;
  logic                           instr_valid_q;
  logic                           illegal_q;

  assign opcode = buf_words_i[0][6:0];
  assign nnn    = buf_words_i[0][14:12];

  // Length of word 0 under the current enables
  always_comb begin
    len_calc   = '0;
    legal_calc = 1'b0;
    case (opcode)
      ENC_64: begin
        len_calc   = Len64;
        legal_calc = en_64_i;
      end
      ENC_GE80: begin
        if (nnn == GE80_N5) begin
          len_calc   = LenGeN5;
          legal_calc = en_ge80_i;
        end else if (nnn == GE80_N1) begin
          len_calc   = LenGeN1;
          legal_calc = en_ge80_i;
        end
      end
      default: legal_calc = 1'b0;  // Standard, compressed, unknown
    endcase
  end

  assign release_now = (state_q == WAIT_REST) && (buf_count_i >= len_q);

  always_comb begin
    state_d   = state_q;
    pop_len_o = '0;
    case (state_q)
      BOOT: begin
        if (boot_cnt_q == BootCntW'(BootCycles - 1)) state_d = IDLE;
      end
      IDLE: begin
        if (buf_count_i != '0) state_d = COMPUTE;
      end
      COMPUTE: begin
        if (legal_calc) begin
          state_d = WAIT_REST;
        end else begin
          state_d   = IDLE;
          pop_len_o = LenW'(1);  // Drop the bad word alone
        end
      end
      WAIT_REST: begin
        if (release_now) begin
          state_d   = IDLE;
          pop_len_o = len_q;
        end
      end
      default: state_d = BOOT;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= BOOT;
      boot_cnt_q    <= '0;
      len_q         <= '0;
      instr_valid_q <= 1'b0;
      illegal_q     <= 1'b0;
    end else begin
      state_q       <= state_d;
      instr_valid_q <= release_now;  // One-cycle pulses
      illegal_q     <= (state_q == COMPUTE) && !legal_calc;
      if (state_q == BOOT) boot_cnt_q <= boot_cnt_q + 1'b1;
      if (state_q == COMPUTE) len_q <= len_calc;
    end
  end

  // Batch capture, words past the length read as zero
  always_ff @(posedge clk_i) begin
    if (release_now) begin
      instr_len_q <= len_q;
      for (int i = 0; i < BufDepth; i++) begin
        instr_q[i] <= (i < int'(len_q)) ? buf_words_i[i] : '0;
      end
    end
  end

  assign instr_o       = instr_q;
  assign instr_len_o   = instr_len_q;
  assign instr_valid_o = instr_valid_q;
  assign illegal_o     = illegal_q;
  assign busy_o        = (state_q != IDLE);  // Also high through boot

endmodule

//--- verilog/isolde_frontend_top.sv
// ##########################################################
// Buffer, decoder and register block of the front end
// Source must hold word_valid_i while full_o is high
// ##########################################################

module isolde_frontend_top import isolde_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Word stream
  input  logic                           word_valid_i,
  input  logic [WordW-1:0]               word_i,
  output logic                           full_o,
  // Register port
  input  logic                           reg_we_i,
  input  logic [RegAddrW-1:0]            reg_addr_i,
  input  logic [WordW-1:0]               reg_wdata_i,
  output logic [WordW-1:0]               reg_rdata_o,
  // Decoded output
  output logic [BufDepth-1:0][WordW-1:0] instr_o,
  output logic [LenW-1:0]                instr_len_o,
  output logic                           instr_valid_o,
  output logic                           illegal_o,
  output logic                           busy_o
);

  logic [BufDepth-1:0][WordW-1:0] buf_words;
  logic [LenW-1:0]                buf_count;
  logic [LenW-1:0]                pop_len;
  logic                           en_64, en_ge80;

  isolde_instr_buffer isolde_instr_buffer_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .word_valid_i(word_valid_i),
    .word_i      (word_i),
    .pop_len_i   (pop_len),
    .words_o     (buf_words),
    .count_o     (buf_count),
    .full_o      (full_o)
  );

  isolde_decoder isolde_decoder_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .buf_words_i  (buf_words),
    .buf_count_i  (buf_count),
    .en_64_i      (en_64),
    .en_ge80_i    (en_ge80),
    .pop_len_o    (pop_len),
    .instr_o      (instr_o),
    .instr_len_o  (instr_len_o),
    .instr_valid_o(instr_valid_o),
    .illegal_o    (illegal_o),
    .busy_o       (busy_o)
  );

  // Counts the decoder pulses, steers its enables
  isolde_cfg_regs isolde_cfg_regs_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .reg_we_i   (reg_we_i),
    .reg_addr_i (reg_addr_i),
    .reg_wdata_i(reg_wdata_i),
    .reg_rdata_o(reg_rdata_o),
    .decoded_i  (instr_valid_o),
    .illegal_i  (illegal_o),
    .en_64_o    (en_64),
    .en_ge80_o  (en_ge80)
  );

endmodule

//--- verilog/isolde_instr_buffer.sv
// ##########################################################
// Five-word shifting buffer, oldest word at index 0
// A push while full_o is high is dropped
// Pop and push in one cycle: push lands after the survivors
// ##########################################################

module isolde_instr_buffer import isolde_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Word stream in
  input  logic                           word_valid_i,
  input  logic [WordW-1:0]               word_i,
  // From decoder
  input  logic [LenW-1:0]                pop_len_i,
  // To decoder
  output logic [BufDepth-1:0][WordW-1:0] words_o,
  output logic [LenW-1:0]                count_o,
  // Back-pressure to source
  output logic                           full_o
);

  logic [BufDepth-1:0][WordW-1:0] words_q, words_d;
  logic [LenW-1:0]                count_q, count_d;
  logic [LenW-1:0]                keep_cnt;  // Entries left after the pop
  logic                           push;

  assign full_o = (count_q == LenW'(BufDepth));
  assign push   = word_valid_i && !full_o;  // Strobe during full is lost

  // Decoder never pops more than it sees
  assign keep_cnt = count_q - pop_len_i;
  assign count_d  = keep_cnt + LenW'(push);

  always_comb begin
    words_d = words_q;
    // Shift survivors down by the pop length
    for (int i = 0; i < BufDepth; i++) begin
      if (i + int'(pop_len_i) < BufDepth) begin
        words_d[i] = words_q[i + int'(pop_len_i)];
      end
    end
    // New word goes right behind the survivors
    if (push) begin
      words_d[keep_cnt] = word_i;
    end
  end

  // Payload only, stale entries beyond count are don't care
  always_ff @(posedge clk_i) begin
    words_q <= words_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else begin
      count_q <= count_d;
    end
  end

  assign words_o = words_q;
  assign count_o = count_q;

endmodule

//--- verilog/isolde_pkg.sv
// ##########################################################
// Shared widths, custom encodings and register map
// Only the two custom encodings are decoded, all else illegal
// ##########################################################

package isolde_pkg;

  // Datapath sizes
  localparam int WordW    = 32;  // One instruction word
  localparam int BufDepth = 5;   // Buffer entries, also longest instruction
  localparam int LenW     = 3;   // Lengths and counts up to BufDepth
  localparam int OpcodeW  = 7;   // Bits 6..0 of word 0
  localparam int NnnW     = 3;   // Bits 14..12 of word 0

  // Decoder stays busy this long after reset release
  localparam int BootCycles = 6;
  localparam int BootCntW   = $clog2(BootCycles);

  // Custom major opcodes
  typedef enum logic [OpcodeW-1:0] {
    ENC_64   = 7'b0111111,  // Always two words
    ENC_GE80 = 7'b1111111   // Length picked by nnn
  } instr_opcode_e;

  // nnn codes under ENC_GE80
  localparam logic [NnnW-1:0] GE80_N5 = 3'h5;  // 160 bit
  localparam logic [NnnW-1:0] GE80_N1 = 3'h1;  // 96 bit

  // Instruction lengths in words
  localparam logic [LenW-1:0] Len64   = 3'd2;
  localparam logic [LenW-1:0] LenGeN1 = 3'd3;
  localparam logic [LenW-1:0] LenGeN5 = 3'd5;

  // Decoder FSM
  typedef enum logic [1:0] {
    BOOT,       // Fixed warm-up after reset
    IDLE,       // Waiting for a first word
    COMPUTE,    // Sizing word 0
    WAIT_REST   // Waiting for the remaining words
  } dec_state_e;

  // Register map
  localparam int RegAddrW = 2;

  typedef enum logic [RegAddrW-1:0] {
    REG_CTRL    = 2'd0,  // Encoding enables
    REG_DECODED = 2'd1,  // Decoded count, write clears
    REG_ILLEGAL = 2'd2   // Illegal count, write clears
  } reg_addr_e;

  // Bits inside REG_CTRL
  localparam int CtrlEn64Bit   = 0;
  localparam int CtrlEnGe80Bit = 1;

endpackage
